/* list.f */
common/host_net_pkg.sv
host_net_ctrl_parser/host_net_ctrl_parser.sv
src/host_net_addr_alloc.sv
src/host_net_req_out.sv
src/host_net_top.sv
bench/tb_host_net_top.sv

/* run.sh */
#!/bin/sh
# Build and run the host_net testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_host_net_top -f list.f
./obj_dir/Vtb_host_net_top 2>&1 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  exit 1
fi
exit 0

/* bench/tb_host_net_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_host_net_top;

  localparam int N_NOTIFY       = 280;
  localparam int TIMEOUT_CYCLES = N_NOTIFY * 40 + 3000;
  localparam longint RING_SIZE  = 64'd1 << host_net_pkg::RING_BITS;

  // One expected host write request
  typedef struct packed {
    host_net_pkg::vaddr_t vaddr;
    host_net_pkg::len_t   len;
    host_net_pkg::pid_t   pid;
    logic [31:0]          cyc;
  } exp_req_t;

  logic aclk;
  logic aresetn;
  logic s_axil_awvalid;
  logic s_axil_awready;
  logic s_axil_wvalid;
  logic s_axil_wready;
  logic s_axil_bvalid;
  logic s_axil_bready;
  logic s_axil_arvalid;
  logic s_axil_arready;
  logic s_axil_rvalid;
  logic s_axil_rready;
  host_net_pkg::axil_addr_t s_axil_awaddr;
  host_net_pkg::axil_addr_t s_axil_araddr;
  host_net_pkg::axil_data_t s_axil_wdata;
  host_net_pkg::axil_data_t s_axil_rdata;
  logic [3:0] s_axil_wstrb;
  logic [1:0] s_axil_bresp;
  logic [1:0] s_axil_rresp;
  logic notify_valid;
  logic notify_ready;
  logic req_valid;
  logic req_ready;
  host_net_pkg::len_t   notify_len;
  host_net_pkg::len_t   req_len;
  host_net_pkg::vaddr_t req_vaddr;
  host_net_pkg::pid_t   req_pid;

  // Reference model state
  host_net_pkg::axil_data_t  regs_m [host_net_pkg::REG_COUNT];
  host_net_pkg::ring_off_t   off_m;
  longint unsigned           total_bytes;
  exp_req_t                  exp_q [$];
  exp_req_t                  pushed_req;
  exp_req_t                  head_req;
  logic [15:0]               lfsr_state;
  logic [31:0]               ready_bits;
  logic [31:0]               len_bits;
  logic                      check_latency;
  logic                      rand_ready;
  logic                      hold_ready;
  int                        cycle;
  int                        stall_cycles;

  host_net_top u_host_net_top (.*);

  //////////////////////////////////////////////////////////////
  // Failure reporting and checks

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want)
    else
    begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, want);
      stop_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Stimulus helpers

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Whole 64 byte slots covered by a packet
  function automatic logic [31:0] slot_step(input host_net_pkg::len_t len);
    slot_step = ((32'(len) + 32'd63) >> host_net_pkg::SLOT_ALIGN_BITS)
                << host_net_pkg::SLOT_ALIGN_BITS;
  endfunction

  function automatic host_net_pkg::vaddr_t model_base();
    model_base = {regs_m[host_net_pkg::REG_VADDR_HI][15:0],
                  regs_m[host_net_pkg::REG_VADDR_LO]};
  endfunction

  function automatic host_net_pkg::axil_data_t model_reg(input host_net_pkg::axil_addr_t addr);
    int idx;
    idx = int'(addr) / 4;
    model_reg = (idx < host_net_pkg::REG_COUNT) ? regs_m[idx] : '0;
  endfunction

  //////////////////////////////////////////////////////////////
  // AXI4-Lite and notify drivers

  task automatic axil_write(input host_net_pkg::axil_addr_t addr,
                            input host_net_pkg::axil_data_t data, input logic [3:0] strb);
    int idx;
    idx = int'(addr) / 4;
    @(posedge aclk);
    s_axil_awvalid <= 1'b1;
    s_axil_awaddr  <= addr;
    s_axil_wvalid  <= 1'b1;
    s_axil_wdata   <= data;
    s_axil_wstrb   <= strb;
    do @(negedge aclk); while (!(s_axil_awready && s_axil_wready));
    // Model takes the write on the coming edge
    if (idx < host_net_pkg::REG_COUNT)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (strb[i])
        begin
          regs_m[idx][i*8 +: 8] = data[i*8 +: 8];
        end
      end
      if (idx == host_net_pkg::REG_VADDR_LO || idx == host_net_pkg::REG_VADDR_HI)
      begin
        off_m = '0;
      end
    end
    @(posedge aclk);
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    // bvalid waits one cycle without bready
    @(posedge aclk);
    s_axil_bready <= 1'b1;
    do @(negedge aclk); while (!s_axil_bvalid);
    check_value("s_axil_bresp", 64'(s_axil_bresp), 64'h0);
    @(posedge aclk);
    s_axil_bready <= 1'b0;
    @(negedge aclk);
  endtask

  task automatic axil_read_check(input host_net_pkg::axil_addr_t addr);
    @(posedge aclk);
    s_axil_arvalid <= 1'b1;
    s_axil_araddr  <= addr;
    do @(negedge aclk); while (!s_axil_arready);
    @(posedge aclk);
    s_axil_arvalid <= 1'b0;
    // rvalid waits one cycle without rready
    @(posedge aclk);
    s_axil_rready  <= 1'b1;
    do @(negedge aclk); while (!s_axil_rvalid);
    check_value("s_axil_rdata", 64'(s_axil_rdata), 64'(model_reg(addr)));
    check_value("s_axil_rresp", 64'(s_axil_rresp), 64'h0);
    @(posedge aclk);
    s_axil_rready <= 1'b0;
    @(negedge aclk);
  endtask

  // Back to back notifications with lengths 1 to 2048
  task automatic send_burst(input int count);
    for (int n = 0; n < count; n++)
    begin
      take_bits(11, len_bits);
      @(posedge aclk);
      notify_valid <= 1'b1;
      notify_len   <= 16'(len_bits[10:0]) + 16'd1;
      do @(negedge aclk); while (!notify_ready);
    end
    @(posedge aclk);
    notify_valid <= 1'b0;
    @(negedge aclk);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
    begin
      @(negedge aclk);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Clock, cycle count, req_ready and watchdog

  initial
  begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    cycle <= cycle + 1;
    if (hold_ready)
    begin
      req_ready <= 1'b0;
    end
    else if (rand_ready)
    begin
      take_bits(1, ready_bits);
      req_ready <= ready_bits[0];
    end
    else
    begin
      req_ready <= 1'b1;
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge aclk);
    $display("Watchdog expired after %0d cycles, the DUT stopped handshaking", TIMEOUT_CYCLES);
    stop_with_failure();
  end

  //////////////////////////////////////////////////////////////
  // Monitors

  // Reference model at the notify handshake
  always @(negedge aclk)
  begin
    if (aresetn && notify_valid && notify_ready)
    begin
      pushed_req.vaddr = model_base() + host_net_pkg::vaddr_t'(off_m);
      pushed_req.len   = notify_len;
      pushed_req.pid   = regs_m[host_net_pkg::REG_PID][host_net_pkg::PID_BITS-1:0];
      pushed_req.cyc   = 32'(cycle);
      exp_q.push_back(pushed_req);
      total_bytes = total_bytes + slot_step(notify_len);
      off_m = host_net_pkg::ring_off_t'((32'(off_m) + slot_step(notify_len)) % RING_SIZE);
    end
  end

  // Requests against the queue head
  always @(negedge aclk)
  begin
    // Only a full pipeline stalls the notify side
    if (aresetn && !notify_ready)
    begin
      stall_cycles = stall_cycles + 1;
      assert (exp_q.size() == 2)
      else abort_run("notify_ready dropped with fewer than two requests pending");
    end
    if (aresetn && req_valid && req_ready)
    begin
      if (exp_q.size() == 0)
      begin
        abort_run("A request came out with no notification pending");
      end
      else
      begin
        head_req = exp_q.pop_front();
        check_value("req_vaddr", 64'(req_vaddr), 64'(head_req.vaddr));
        check_value("req_len", 64'(req_len), 64'(head_req.len));
        check_value("req_pid", 64'(req_pid), 64'(head_req.pid));
        if (check_latency)
        begin
          check_value("req_valid latency", 64'(cycle - int'(head_req.cyc)), 64'd2);
        end
      end
    end
  end

  a_req_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (req_valid && !req_ready) |=> (req_valid && $stable(req_vaddr) &&
                                   $stable(req_len) && $stable(req_pid)))
  else abort_run("Held request dropped or changed while req_ready was low");

  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (s_axil_bvalid && !s_axil_bready) |=> s_axil_bvalid)
  else abort_run("Write response dropped before bready");

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (s_axil_rvalid && !s_axil_rready) |=> (s_axil_rvalid && $stable(s_axil_rdata)))
  else abort_run("Read data dropped or changed before rready");

  //////////////////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    aresetn        = 1'b0;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_bready  = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_araddr  = '0;
    s_axil_rready  = 1'b0;
    notify_valid   = 1'b0;
    notify_len     = '0;
    req_ready      = 1'b1;
    lfsr_state     = 16'd91;
    off_m          = '0;
    total_bytes    = 0;
    cycle          = 0;
    stall_cycles   = 0;
    check_latency  = 1'b0;
    rand_ready     = 1'b0;
    hold_ready     = 1'b0;
    for (int r = 0; r < host_net_pkg::REG_COUNT; r++)
    begin
      regs_m[r] = '0;
    end
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);

    // Reset levels and zero readback
    check_value("s_axil_awready", 64'(s_axil_awready), 64'h0);
    check_value("s_axil_wready", 64'(s_axil_wready), 64'h0);
    check_value("s_axil_bvalid", 64'(s_axil_bvalid), 64'h0);
    check_value("s_axil_arready", 64'(s_axil_arready), 64'h0);
    check_value("s_axil_rvalid", 64'(s_axil_rvalid), 64'h0);
    check_value("req_valid", 64'(req_valid), 64'h0);
    check_value("notify_ready", 64'(notify_ready), 64'h1);
    for (int a = 0; a < 16; a += 4)
    begin
      axil_read_check(4'(a));
    end

    // Byte strobes and the unmapped word
    axil_write(4'h0, 32'h1234_5678, 4'hF);
    axil_read_check(4'h0);
    axil_write(4'h0, 32'hAABB_CCDD, 4'b0101);
    axil_read_check(4'h0);
    axil_write(4'h4, 32'h0000_7F3C, 4'b0011);
    axil_write(4'h4, 32'hFFFF_FF00, 4'b0100);
    axil_read_check(4'h4);
    axil_write(4'h8, 32'hFFFF_FF15, 4'b0001);
    axil_read_check(4'h8);
    axil_write(4'hC, 32'hDEAD_BEEF, 4'hF);
    axil_read_check(4'hC);

    // Fixed latency then enough bytes to wrap the ring
    check_latency = 1'b1;
    send_burst(20);
    wait_drain();
    send_burst(150);
    wait_drain();
    assert (total_bytes > RING_SIZE)
    else abort_run("Traffic never went past the end of the ring");

    // Random back-pressure
    check_latency = 1'b0;
    rand_ready    = 1'b1;
    send_burst(100);
    rand_ready    = 1'b0;
    wait_drain();
    assert (stall_cycles > 0)
    else abort_run("Back-pressure never filled both stages");

    // Base restart between packets
    check_latency = 1'b1;
    send_burst(3);
    wait_drain();
    axil_write(4'h0, 32'h0001_0040, 4'hF);
    send_burst(3);
    wait_drain();

    // PID write while a request waits in the output stage
    check_latency = 1'b0;
    hold_ready    = 1'b1;
    send_burst(1);
    axil_write(4'h8, 32'h0000_002A, 4'hF);
    axil_read_check(4'h8);
    hold_ready    = 1'b0;
    wait_drain();

    // New PID on later packets
    check_latency = 1'b1;
    send_burst(3);
    wait_drain();
    repeat (4) @(negedge aclk);

    if (exp_q.size() == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      abort_run("Requests still missing at the end of the run");
    end
  end

endmodule

`default_nettype wire

/* src/host_net_top.sv */
`timescale 1ns/10ps
`default_nettype none

module host_net_top (
  input  wire logic                     aclk,
  input  wire logic                     aresetn,

  // AXI4-Lite control
  input  wire logic                     s_axil_awvalid,
  output logic                          s_axil_awready,
  input  wire host_net_pkg::axil_addr_t s_axil_awaddr,
  input  wire logic                     s_axil_wvalid,
  output logic                          s_axil_wready,
  input  wire host_net_pkg::axil_data_t s_axil_wdata,
  input  wire logic [3:0]               s_axil_wstrb,
  output logic                          s_axil_bvalid,
  input  wire logic                     s_axil_bready,
  output logic [1:0]                    s_axil_bresp,
  input  wire logic                     s_axil_arvalid,
  output logic                          s_axil_arready,
  input  wire host_net_pkg::axil_addr_t s_axil_araddr,
  output logic                          s_axil_rvalid,
  input  wire logic                     s_axil_rready,
  output host_net_pkg::axil_data_t      s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,

  // Packet notifications
  input  wire logic                     notify_valid,
  output logic                          notify_ready,
  input  wire host_net_pkg::len_t       notify_len,

  // Host write requests
  output logic                          req_valid,
  input  wire logic                     req_ready,
  output host_net_pkg::vaddr_t          req_vaddr,
  output host_net_pkg::len_t            req_len,
  output host_net_pkg::pid_t            req_pid
);

  host_net_pkg::vaddr_t base_vaddr;
  host_net_pkg::pid_t   pid;
  logic                 base_load;

  // Allocator to output stage
  logic                 alloc_valid;
  logic                 alloc_ready;
  host_net_pkg::vaddr_t alloc_vaddr;
  host_net_pkg::len_t   alloc_len;

  //////////////////////////////////////////////////////////////
  // Control registers

  host_net_ctrl_parser u_ctrl_parser (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .awvalid    (s_axil_awvalid),
    .awready    (s_axil_awready),
    .awaddr     (s_axil_awaddr),
    .wvalid     (s_axil_wvalid),
    .wready     (s_axil_wready),
    .wdata      (s_axil_wdata),
    .wstrb      (s_axil_wstrb),
    .bvalid     (s_axil_bvalid),
    .bready     (s_axil_bready),
    .bresp      (s_axil_bresp),
    .arvalid    (s_axil_arvalid),
    .arready    (s_axil_arready),
    .araddr     (s_axil_araddr),
    .rvalid     (s_axil_rvalid),
    .rready     (s_axil_rready),
    .rdata      (s_axil_rdata),
    .rresp      (s_axil_rresp),
    .base_vaddr (base_vaddr),
    .pid        (pid),
    .base_load  (base_load)
  );

  //////////////////////////////////////////////////////////////
  // Two stage request pipeline

  host_net_addr_alloc u_addr_alloc (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .notify_valid (notify_valid),
    .notify_ready (notify_ready),
    .notify_len   (notify_len),
    .base_vaddr   (base_vaddr),
    .base_load    (base_load),
    .out_valid    (alloc_valid),
    .out_ready    (alloc_ready),
    .out_vaddr    (alloc_vaddr),
    .out_len      (alloc_len)
  );

  host_net_req_out u_req_out (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (alloc_valid),
    .in_ready  (alloc_ready),
    .in_vaddr  (alloc_vaddr),
    .in_len    (alloc_len),
    .pid       (pid),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_vaddr (req_vaddr),
    .req_len   (req_len),
    .req_pid   (req_pid)
  );

endmodule

`default_nettype wire

/* src/host_net_req_out.sv */
`timescale 1ns/10ps
`default_nettype none

module host_net_req_out (
  input  wire logic                 aclk,
  input  wire logic                 aresetn,

  // From the allocator
  input  wire logic                 in_valid,
  output logic                      in_ready,
  input  wire host_net_pkg::vaddr_t in_vaddr,
  input  wire host_net_pkg::len_t   in_len,
  // Live PID register
  input  wire host_net_pkg::pid_t   pid,

  // Host write request
  output logic                      req_valid,
  input  wire logic                 req_ready,
  output host_net_pkg::vaddr_t      req_vaddr,
  output host_net_pkg::len_t        req_len,
  output host_net_pkg::pid_t        req_pid
);

  logic in_fire;

  // Take a new item when empty or when the held one leaves
  assign in_ready = !req_valid || req_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      req_valid <= 1'b0;
    end
    else if (in_fire)
    begin
      req_valid <= 1'b1;
    end
    else if (req_ready)
    begin
      req_valid <= 1'b0;
    end
  end

  // PID frozen with the request
  always_ff @(posedge aclk)
  begin
    if (in_fire)
    begin
      req_vaddr <= in_vaddr;
      req_len   <= in_len;
      req_pid   <= pid;
    end
  end

endmodule

`default_nettype wire

/* src/host_net_addr_alloc.sv */
`timescale 1ns/10ps
`default_nettype none

module host_net_addr_alloc (
  input  wire logic                 aclk,
  input  wire logic                 aresetn,

  // Packet notifications
  input  wire logic                 notify_valid,
  output logic                      notify_ready,
  input  wire host_net_pkg::len_t   notify_len,

  // Ring base from the control registers
  input  wire host_net_pkg::vaddr_t base_vaddr,
  input  wire logic                 base_load,

  // Towards the output stage
  output logic                      out_valid,
  input  wire logic                 out_ready,
  output host_net_pkg::vaddr_t      out_vaddr,
  output host_net_pkg::len_t        out_len
);

  host_net_pkg::ring_off_t               offset;
  // Offset seen by the packet accepted this cycle
  host_net_pkg::ring_off_t               cur_off;
  logic [host_net_pkg::LEN_BITS:0]       len_pad;
  logic [host_net_pkg::LEN_BITS:0]       step;
  logic                                  notify_fire;

  // Room when empty or when the held item leaves
  assign notify_ready = !out_valid || out_ready;
  assign notify_fire  = notify_valid && notify_ready;

  // Pending base write clears the offset first
  assign cur_off = base_load ? '0 : offset;

  // Length rounded up to a whole slot, one extra bit for 64 KiB
  assign len_pad = {1'b0, notify_len} + ((1 << host_net_pkg::SLOT_ALIGN_BITS) - 1);
  assign step    = {len_pad[host_net_pkg::LEN_BITS:host_net_pkg::SLOT_ALIGN_BITS],
                    {host_net_pkg::SLOT_ALIGN_BITS{1'b0}}};

  //////////////////////////////////////////////////////////////
  // Running ring offset

  // Wraps by truncation to the ring width
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      offset <= '0;
    end
    else if (notify_fire)
    begin
      offset <= cur_off + step[host_net_pkg::RING_BITS-1:0];
    end
    else if (base_load)
    begin
      offset <= '0;
    end
  end

  //////////////////////////////////////////////////////////////
  // One entry output register

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      out_valid <= 1'b0;
    end
    else if (notify_fire)
    begin
      out_valid <= 1'b1;
    end
    else if (out_ready)
    begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (notify_fire)
    begin
      out_vaddr <= base_vaddr + host_net_pkg::vaddr_t'(cur_off);
      out_len   <= notify_len;
    end
  end

endmodule

`default_nettype wire

/* host_net_ctrl_parser/host_net_ctrl_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module host_net_ctrl_parser (
  input  wire logic                    aclk,
  input  wire logic                    aresetn,

  // AXI4-Lite write address and data
  input  wire logic                    awvalid,
  output logic                         awready,
  input  wire host_net_pkg::axil_addr_t awaddr,
  input  wire logic                    wvalid,
  output logic                         wready,
  input  wire host_net_pkg::axil_data_t wdata,
  input  wire logic [3:0]              wstrb,

  // AXI4-Lite write response
  output logic                         bvalid,
  input  wire logic                    bready,
  output logic [1:0]                   bresp,

  // AXI4-Lite read
  input  wire logic                    arvalid,
  output logic                         arready,
  input  wire host_net_pkg::axil_addr_t araddr,
  output logic                         rvalid,
  input  wire logic                    rready,
  output host_net_pkg::axil_data_t     rdata,
  output logic [1:0]                   rresp,

  // To the pipeline
  output host_net_pkg::vaddr_t         base_vaddr,
  output host_net_pkg::pid_t           pid,
  output logic                         base_load
);

  //////////////////////////////////////////////////////////////
  // Register file and handshake state

  host_net_pkg::axil_data_t regs [host_net_pkg::REG_COUNT];

  // Address and data ready pulse together
  logic                             aw_wready;
  // Cleared while a write response is outstanding
  logic                             aw_en;
  host_net_pkg::axil_addr_t         aw_addr;
  host_net_pkg::axil_addr_t         ar_addr;
  logic [host_net_pkg::REG_IDX_BITS-1:0] wr_idx;
  logic [host_net_pkg::REG_IDX_BITS-1:0] rd_idx;
  logic                             wr_fire;
  host_net_pkg::axil_data_t         rd_word;

  assign awready = aw_wready;
  assign wready  = aw_wready;

  // Always OKAY, unmapped space included
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  assign wr_idx  = aw_addr[host_net_pkg::AXIL_ADDR_BITS-1:host_net_pkg::AXIL_ADDR_LSB];
  assign rd_idx  = ar_addr[host_net_pkg::AXIL_ADDR_BITS-1:host_net_pkg::AXIL_ADDR_LSB];
  assign wr_fire = aw_wready && awvalid && wvalid;

  //////////////////////////////////////////////////////////////
  // Write channel

  // Wait for address and data together, one write at a time
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      aw_wready <= 1'b0;
      aw_en     <= 1'b1;
      aw_addr   <= '0;
    end
    else if (!aw_wready && awvalid && wvalid && aw_en)
    begin
      aw_wready <= 1'b1;
      aw_en     <= 1'b0;
      aw_addr   <= awaddr;
    end
    else if (bvalid && bready)
    begin
      aw_wready <= 1'b0;
      aw_en     <= 1'b1;
    end
    else
    begin
      aw_wready <= 1'b0;
    end
  end

  // Byte lane update on the handshake edge
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int r = 0; r < host_net_pkg::REG_COUNT; r++)
      begin
        regs[r] <= '0;
      end
    end
    else if (wr_fire && (int'(wr_idx) < host_net_pkg::REG_COUNT))
    begin
      for (int i = 0; i < host_net_pkg::AXIL_DATA_BITS / 8; i++)
      begin
        if (wstrb[i])
        begin
          regs[wr_idx][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // Response, held until bready
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bvalid <= 1'b0;
    end
    else if (wr_fire && !bvalid)
    begin
      bvalid <= 1'b1;
    end
    else if (bvalid && bready)
    begin
      bvalid <= 1'b0;
    end
  end

  // Either address word restarts the ring
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      base_load <= 1'b0;
    end
    else
    begin
      base_load <= wr_fire &&
                   ((int'(wr_idx) == host_net_pkg::REG_VADDR_LO) ||
                    (int'(wr_idx) == host_net_pkg::REG_VADDR_HI));
    end
  end

  //////////////////////////////////////////////////////////////
  // Read channel

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arready <= 1'b0;
      ar_addr <= '0;
    end
    else if (!arready && arvalid)
    begin
      arready <= 1'b1;
      ar_addr <= araddr;
    end
    else
    begin
      arready <= 1'b0;
    end
  end

  // Readback mux, zero outside the map
  always_comb
  begin
    case (int'(rd_idx))
      host_net_pkg::REG_VADDR_LO: rd_word = regs[host_net_pkg::REG_VADDR_LO];
      host_net_pkg::REG_VADDR_HI: rd_word = regs[host_net_pkg::REG_VADDR_HI];
      host_net_pkg::REG_PID:      rd_word = regs[host_net_pkg::REG_PID];
      default:                    rd_word = '0;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rvalid <= 1'b0;
    end
    else if (arready && arvalid && !rvalid)
    begin
      rvalid <= 1'b1;
    end
    else if (rvalid && rready)
    begin
      rvalid <= 1'b0;
    end
  end

  // Data word captured with rvalid
  always_ff @(posedge aclk)
  begin
    if (arready && arvalid && !rvalid)
    begin
      rdata <= rd_word;
    end
  end

  //////////////////////////////////////////////////////////////
  // Register fields to the pipeline

  assign base_vaddr = {regs[host_net_pkg::REG_VADDR_HI]
                         [host_net_pkg::VADDR_BITS-host_net_pkg::AXIL_DATA_BITS-1:0],
                       regs[host_net_pkg::REG_VADDR_LO]};
  assign pid        = regs[host_net_pkg::REG_PID][host_net_pkg::PID_BITS-1:0];

endmodule

`default_nettype wire

/* common/host_net_pkg.sv */
`default_nettype none

package host_net_pkg;

  //////////////////////////////////////////////////////////////
  // Control port
  localparam int AXIL_DATA_BITS = 32;
  localparam int AXIL_ADDR_BITS = 4;
  // Byte offset bits inside one control word
  localparam int AXIL_ADDR_LSB  = $clog2(AXIL_DATA_BITS / 8);
  localparam int REG_IDX_BITS   = AXIL_ADDR_BITS - AXIL_ADDR_LSB;

  // Register map, word indices
  localparam int REG_VADDR_LO = 0;
  localparam int REG_VADDR_HI = 1;
  localparam int REG_PID      = 2;
  localparam int REG_COUNT    = 3;

  //////////////////////////////////////////////////////////////
  // Request fields
  localparam int VADDR_BITS = 48;
  localparam int PID_BITS   = 6;
  localparam int LEN_BITS   = 16;

  // Ring geometry, 64 byte slots in a 64 KiB ring
  localparam int SLOT_ALIGN_BITS = 6;
  localparam int RING_BITS       = 16;

  typedef logic [AXIL_DATA_BITS-1:0] axil_data_t;
  typedef logic [AXIL_ADDR_BITS-1:0] axil_addr_t;
  typedef logic [VADDR_BITS-1:0]     vaddr_t;
  typedef logic [PID_BITS-1:0]       pid_t;
  typedef logic [LEN_BITS-1:0]       len_t;
  typedef logic [RING_BITS-1:0]      ring_off_t;

endpackage

`default_nettype wire
